//--- project.f
source/cap_rf_pkg.sv
source/rf_wb_if.sv
source/rf_rd_if.sv
source/tag_revoker.sv
source/cheri_regfile.sv
source/operand_reader.sv
source/cap_rf_top.sv
test/cap_rf_assertions.sv
test/cap_rf_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the capability register file testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module cap_rf_tb \
  -f project.f -o cap_rf_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/cap_rf_sim 2>&1)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
  exit 0
else
  exit 1
fi

//--- source/cap_rf_pkg.sv
package cap_rf_pkg;

  ////////////////////////////////////////
  // Register file geometry
  ////////////////////////////////////////

  // Capability reduced to address plus one tag bit
  parameter int unsigned DataWidth = 32;
  parameter int unsigned RegAddrWidth = 5;

  typedef logic [RegAddrWidth-1:0] reg_addr_t;

  ////////////////////////////////////////
  // Temporal safety map
  ////////////////////////////////////////

  // Word address into the shadow memory
  parameter int unsigned TsAddrWidth = 16;

  // One revocation bit per 8-byte granule
  parameter int unsigned TsGranuleShift = 3;

  // Heap covered by the map
  parameter logic [DataWidth-1:0] DefaultHeapBase = 32'h2001_0000;

  // Map size in 32-bit words
  parameter int unsigned DefaultTsMapSize = 1024;

endpackage

//--- source/cap_rf_top.sv
`timescale 1ns/1ps

module cap_rf_top #(
  parameter int unsigned                       NRegs     = 32,
  parameter logic [cap_rf_pkg::DataWidth-1:0]  HeapBase  = cap_rf_pkg::DefaultHeapBase,
  parameter int unsigned                       TsMapSize = cap_rf_pkg::DefaultTsMapSize
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  // Write-back
  input  logic                               wb_valid_i,
  input  cap_rf_pkg::reg_addr_t              wb_addr_i,
  input  logic [cap_rf_pkg::DataWidth-1:0]   wb_data_i,
  input  logic                               wb_tag_i,

  // TS map memory
  output logic                               tsmap_cs_o,
  output logic [cap_rf_pkg::TsAddrWidth-1:0] tsmap_addr_o,
  input  logic [31:0]                        tsmap_rdata_i,

  // Operand read
  input  logic                               rd_req_i,
  input  cap_rf_pkg::reg_addr_t              rd_addr_i,
  output logic                               rd_stall_o,
  output logic                               rd_valid_o,
  output logic [cap_rf_pkg::DataWidth-1:0]   rd_data_o,
  output logic                               rd_tag_o
);

  rf_wb_if u_wb_if ();
  rf_rd_if u_rd_if ();

  tag_revoker #(
    .NRegs     (NRegs),
    .HeapBase  (HeapBase),
    .TsMapSize (TsMapSize)
  ) u_tag_revoker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wb_valid_i    (wb_valid_i),
    .wb_addr_i     (wb_addr_i),
    .wb_data_i     (wb_data_i),
    .wb_tag_i      (wb_tag_i),
    .tsmap_cs_o    (tsmap_cs_o),
    .tsmap_addr_o  (tsmap_addr_o),
    .tsmap_rdata_i (tsmap_rdata_i),
    .wb            (u_wb_if.producer)
  );

  cheri_regfile #(
    .NRegs (NRegs)
  ) u_cheri_regfile (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wb     (u_wb_if.buffer),
    .rd     (u_rd_if.buffer)
  );

  operand_reader u_operand_reader (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_req_i   (rd_req_i),
    .rd_addr_i  (rd_addr_i),
    .rd_stall_o (rd_stall_o),
    .rd_valid_o (rd_valid_o),
    .rd_data_o  (rd_data_o),
    .rd_tag_o   (rd_tag_o),
    .rd         (u_rd_if.consumer)
  );

endmodule

//--- source/cheri_regfile.sv
`timescale 1ns/1ps

module cheri_regfile #(
  parameter int unsigned NRegs = 32
) (
  input  logic      clk_i,
  input  logic      rst_ni,

  rf_wb_if.buffer   wb,
  rf_rd_if.buffer   rd
);
  import cap_rf_pkg::*;

  // Register 0 has no storage
  logic [DataWidth-1:0] data_q [1:NRegs-1];
  logic [NRegs-1:1]     tag_q;
  logic [NRegs-1:1]     rdy_q;

  ////////////////////////////////////////
  // Update
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NRegs; i++) begin
        data_q[i] <= '0;
      end
      tag_q <= '0;
      rdy_q <= '1;
    end else begin
      for (int i = 1; i < NRegs; i++) begin
        // Plain write leaves the register ready
        if (wb.we && (wb.waddr == reg_addr_t'(i))) begin
          data_q[i] <= wb.wdata;
          tag_q[i]  <= wb.wtag;
          rdy_q[i]  <= 1'b1;
        end
        // Reservation overrides the ready set above
        if (wb.trsv_en && (wb.trsv_addr == reg_addr_t'(i))) begin
          rdy_q[i] <= 1'b0;
        end
        // Revocation only touches tag and ready
        if (wb.trvk_en && (wb.trvk_addr == reg_addr_t'(i))) begin
          rdy_q[i] <= 1'b1;
          if (wb.trvk_clrtag) begin
            tag_q[i] <= 1'b0;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // Read
  ////////////////////////////////////////

  // Zero, untagged and ready unless a stored register matches
  always_comb begin
    rd.rdata = '0;
    rd.rtag  = 1'b0;
    rd.rdy   = 1'b1;
    for (int i = 1; i < NRegs; i++) begin
      if (rd.raddr == reg_addr_t'(i)) begin
        rd.rdata = data_q[i];
        rd.rtag  = tag_q[i];
        rd.rdy   = rdy_q[i];
      end
    end
  end

endmodule

//--- source/operand_reader.sv
`timescale 1ns/1ps

module operand_reader (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  input  logic                             rd_req_i,
  input  cap_rf_pkg::reg_addr_t            rd_addr_i,
  output logic                             rd_stall_o,
  output logic                             rd_valid_o,
  output logic [cap_rf_pkg::DataWidth-1:0] rd_data_o,
  output logic                             rd_tag_o,

  rf_rd_if.consumer                        rd
);
  import cap_rf_pkg::*;

  typedef enum logic {
    StIdle,
    StWait
  } state_e;

  state_e               state_q, state_d;
  reg_addr_t            pend_q;
  logic                 capture;
  logic                 rd_valid_q;
  logic [DataWidth-1:0] rd_data_q;
  logic                 rd_tag_q;

  // Held address while waiting, new request otherwise
  assign rd.raddr   = (state_q == StWait) ? pend_q : rd_addr_i;
  assign rd_stall_o = (state_q == StWait);

  assign capture = (state_q == StWait) ? rd.rdy : (rd_req_i && rd.rdy);

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle: begin
        if (rd_req_i && !rd.rdy) begin
          state_d = StWait;
        end
      end
      StWait: begin
        if (rd.rdy) begin
          state_d = StIdle;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= StIdle;
      rd_valid_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      rd_valid_q <= capture;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == StIdle) && rd_req_i) begin
      pend_q <= rd_addr_i;
    end
    if (capture) begin
      rd_data_q <= rd.rdata;
      rd_tag_q  <= rd.rtag;
    end
  end

  assign rd_valid_o = rd_valid_q;
  assign rd_data_o  = rd_data_q;
  assign rd_tag_o   = rd_tag_q;

endmodule

//--- source/rf_rd_if.sv
`timescale 1ns/1ps

interface rf_rd_if;
  import cap_rf_pkg::*;

  // Address from the reader
  reg_addr_t            raddr;

  // Contents of the addressed register, combinational
  logic [DataWidth-1:0] rdata;
  logic                 rtag;
  logic                 rdy;

  modport consumer (
    output raddr,
    input  rdata, rtag, rdy
  );

  modport buffer (
    input  raddr,
    output rdata, rtag, rdy
  );

endinterface

//--- source/rf_wb_if.sv
`timescale 1ns/1ps

interface rf_wb_if;
  import cap_rf_pkg::*;

  // Write-back write
  logic                 we;
  reg_addr_t            waddr;
  logic [DataWidth-1:0] wdata;
  logic                 wtag;

  // Reservation of a register whose check is pending
  logic                 trsv_en;
  reg_addr_t            trsv_addr;

  // Revocation result
  logic                 trvk_en;
  reg_addr_t            trvk_addr;
  logic                 trvk_clrtag;

  modport producer (
    output we, waddr, wdata, wtag,
    output trsv_en, trsv_addr,
    output trvk_en, trvk_addr, trvk_clrtag
  );

  modport buffer (
    input we, waddr, wdata, wtag,
    input trsv_en, trsv_addr,
    input trvk_en, trvk_addr, trvk_clrtag
  );

endinterface

//--- source/tag_revoker.sv
`timescale 1ns/1ps

module tag_revoker #(
  parameter int unsigned                       NRegs     = 32,
  parameter logic [cap_rf_pkg::DataWidth-1:0]  HeapBase  = cap_rf_pkg::DefaultHeapBase,
  parameter int unsigned                       TsMapSize = cap_rf_pkg::DefaultTsMapSize
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  input  logic                               wb_valid_i,
  input  cap_rf_pkg::reg_addr_t              wb_addr_i,
  input  logic [cap_rf_pkg::DataWidth-1:0]   wb_data_i,
  input  logic                               wb_tag_i,

  output logic                               tsmap_cs_o,
  output logic [cap_rf_pkg::TsAddrWidth-1:0] tsmap_addr_o,
  input  logic [31:0]                        tsmap_rdata_i,

  rf_wb_if.producer                          wb
);
  import cap_rf_pkg::*;

  // 32 revocation bits per map word
  localparam int unsigned BitIdxWidth = 5;
  localparam logic [DataWidth-1:0] HeapSpan =
      DataWidth'(TsMapSize) << (TsGranuleShift + BitIdxWidth);

  logic                   wr_ok;
  logic                   in_heap;
  logic                   checked;
  logic [DataWidth-1:0]   heap_off;
  logic [DataWidth-1:0]   granule;
  logic [TsAddrWidth-1:0] lookup_word;
  logic [BitIdxWidth-1:0] lookup_bit;

  // Pipeline stages
  logic                   s1_live_q, s2_live_q;
  reg_addr_t              s1_addr_q, s2_addr_q;
  logic [BitIdxWidth-1:0] s1_bit_q, s2_bit_q;
  logic [TsAddrWidth-1:0] s1_word_q;
  logic                   s1_hit, s2_hit;

  ////////////////////////////////////////
  // Accept and range check
  ////////////////////////////////////////

  // Register 0 and registers beyond NRegs are never written
  assign wr_ok = wb_valid_i && (wb_addr_i != '0) && (32'(wb_addr_i) < NRegs);

  assign heap_off    = wb_data_i - HeapBase;
  assign in_heap     = (wb_data_i >= HeapBase) && (heap_off < HeapSpan);
  assign checked     = wr_ok && wb_tag_i && in_heap;

  assign granule     = heap_off >> TsGranuleShift;
  assign lookup_word = granule[BitIdxWidth +: TsAddrWidth];
  assign lookup_bit  = granule[BitIdxWidth-1:0];

  assign wb.we     = wr_ok;
  assign wb.waddr  = wb_addr_i;
  assign wb.wdata  = wb_data_i;
  assign wb.wtag   = wb_tag_i;

  // Checked writes hold the register until resolved
  assign wb.trsv_en   = checked;
  assign wb.trsv_addr = wb_addr_i;

  ////////////////////////////////////////
  // Lookup and resolve
  ////////////////////////////////////////

  // A newer write to the same register kills the older check
  assign s1_hit = wr_ok && (wb_addr_i == s1_addr_q);
  assign s2_hit = wr_ok && (wb_addr_i == s2_addr_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_live_q <= 1'b0;
      s2_live_q <= 1'b0;
    end else begin
      s1_live_q <= checked;
      s2_live_q <= s1_live_q && !s1_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_addr_q <= wb_addr_i;
    s1_word_q <= lookup_word;
    s1_bit_q  <= lookup_bit;
    s2_addr_q <= s1_addr_q;
    s2_bit_q  <= s1_bit_q;
  end

  // Map read issued in the cycle after accept
  assign tsmap_cs_o   = s1_live_q;
  assign tsmap_addr_o = s1_word_q;

  // Map word arrives one cycle later
  assign wb.trvk_en     = s2_live_q && !s2_hit;
  assign wb.trvk_addr   = s2_addr_q;
  assign wb.trvk_clrtag = tsmap_rdata_i[s2_bit_q];

endmodule

//--- test/cap_rf_assertions.sv
`timescale 1ns/1ps

module cap_rf_assertions #(
  parameter logic [cap_rf_pkg::DataWidth-1:0] HeapBase  = cap_rf_pkg::DefaultHeapBase,
  parameter int unsigned                      TsMapSize = cap_rf_pkg::DefaultTsMapSize
) (
  input logic                             clk_i,
  input logic                             rst_ni,
  input logic                             wb_valid_i,
  input cap_rf_pkg::reg_addr_t            wb_addr_i,
  input logic [cap_rf_pkg::DataWidth-1:0] wb_data_i,
  input logic                             wb_tag_i,
  input logic                             tsmap_cs_i,
  input logic                             rvk_en_i,
  input cap_rf_pkg::reg_addr_t            rvk_addr_i,
  input logic                             rd_stall_i,
  input logic                             rd_valid_i
);
  import cap_rf_pkg::*;

  // First byte past the heap, 256 bytes per map word
  localparam logic [DataWidth-1:0] HeapEnd = HeapBase + DataWidth'(TsMapSize) * 256;

  logic        checked_wr;
  int unsigned fail_cnt = 0;

  assign checked_wr = wb_valid_i && wb_tag_i && (wb_addr_i != '0) &&
                      (wb_data_i >= HeapBase) && (wb_data_i < HeapEnd);

  // Lookup one edge after a checked write, and only then
  cs_after_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    checked_wr |=> tsmap_cs_i)
    else begin
      fail_cnt++;
      $error("tsmap_cs_o missing after checked write");
    end

  cs_needs_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tsmap_cs_i |-> $past(checked_wr))
    else begin
      fail_cnt++;
      $error("tsmap_cs_o without checked write");
    end

  // Revocations only ever target stored registers
  no_write_r0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvk_en_i |-> (rvk_addr_i != '0))
    else begin
      fail_cnt++;
      $error("Revocation aimed at register 0");
    end

  valid_not_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(rd_valid_i) |-> !rd_stall_i)
    else begin
      fail_cnt++;
      $error("rd_valid_o rose during stall");
    end

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !tsmap_cs_i && !rd_stall_i && !rd_valid_i)
    else begin
      fail_cnt++;
      $error("Outputs active during reset");
    end

endmodule

bind tag_revoker cap_rf_assertions #(
  .HeapBase  (HeapBase),
  .TsMapSize (TsMapSize)
) u_revoker_assertions (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .wb_valid_i (wb_valid_i),
  .wb_addr_i  (wb_addr_i),
  .wb_data_i  (wb_data_i),
  .wb_tag_i   (wb_tag_i),
  .tsmap_cs_i (tsmap_cs_o),
  .rvk_en_i   (s2_live_q),
  .rvk_addr_i (s2_addr_q),
  .rd_stall_i (1'b0),
  .rd_valid_i (1'b0)
);

bind operand_reader cap_rf_assertions u_reader_assertions (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .wb_valid_i (1'b0),
  .wb_addr_i  ('0),
  .wb_data_i  ('0),
  .wb_tag_i   (1'b0),
  .tsmap_cs_i (1'b0),
  .rvk_en_i   (1'b0),
  .rvk_addr_i ('0),
  .rd_stall_i (rd_stall_o),
  .rd_valid_i (rd_valid_o)
);

//--- test/cap_rf_tb.sv
`timescale 1ns/1ps

module cap_rf_tb;
  import cap_rf_pkg::*;

  localparam int NRegs = 32;
  localparam int NumDirectedOps = 80;
  localparam int NumRandomOps = 400;
  localparam int TimeoutNs = (NumDirectedOps + NumRandomOps) * 20 * 4;
  localparam logic [31:0] HeapSpan = DefaultTsMapSize * 32 * 8;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   wb_valid_i;
  reg_addr_t              wb_addr_i;
  logic [DataWidth-1:0]   wb_data_i;
  logic                   wb_tag_i;
  logic                   tsmap_cs_o;
  logic [TsAddrWidth-1:0] tsmap_addr_o;
  logic [31:0]            tsmap_rdata_i = '0;
  logic                   rd_req_i;
  reg_addr_t              rd_addr_i;
  logic                   rd_stall_o;
  logic                   rd_valid_o;
  logic [DataWidth-1:0]   rd_data_o;
  logic                   rd_tag_o;

  // Shadow memory contents and expected register state
  logic [31:0]            ts_mem [DefaultTsMapSize];
  logic                   ts_cs_q = 1'b0;
  logic [TsAddrWidth-1:0] ts_addr_q;
  logic [31:0]            rng_state = 32'd72;
  logic [31:0]            m_data [NRegs];
  logic                   m_tag [NRegs];
  logic                   m_clr [NRegs];
  int                     m_due [NRegs];
  int                     valid_cnt = 0;

  cap_rf_top #(
    .NRegs (NRegs)
  ) uut (.*);

  always #2 clk_i = ~clk_i;

  // Synchronous RAM, word appears one cycle after chip select
  always @(negedge clk_i) begin
    if (ts_cs_q) begin
      tsmap_rdata_i = ts_mem[ts_addr_q[9:0]];
    end
    ts_cs_q = tsmap_cs_o;
    ts_addr_q = tsmap_addr_o;
  end

  ////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift_next();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] heap_rand();
    return DefaultHeapBase + (xorshift_next() % HeapSpan);
  endfunction

  function automatic logic checked_write(input logic [31:0] data, input logic tag);
    return tag && (data >= DefaultHeapBase) && (data < DefaultHeapBase + HeapSpan);
  endfunction

  // Revocation bit of the granule holding this address
  function automatic logic expect_revoked(input logic [31:0] data);
    logic [31:0] granule;
    granule = (data - DefaultHeapBase) >> TsGranuleShift;
    return ts_mem[granule[14:5]][granule[4:0]];
  endfunction

  // Failures flagged by the bound checkers
  function automatic int unsigned assertion_failures();
    return uut.u_tag_revoker.u_revoker_assertions.fail_cnt +
           uut.u_operand_reader.u_reader_assertions.fail_cnt;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "Check of %s failed", name);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic drive_cycle(input logic wv, input reg_addr_t wa, input logic [31:0] wd,
                             input logic wt, input logic rq, input reg_addr_t ra);
    @(negedge clk_i);
    wb_valid_i = wv;
    wb_addr_i = wa;
    wb_data_i = wd;
    wb_tag_i = wt;
    rd_req_i = rq;
    rd_addr_i = ra;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic write_reg(input reg_addr_t a, input logic [31:0] d, input logic t);
    drive_cycle(1'b1, a, d, t, 1'b0, '0);
  endtask

  // Returns once the read is no longer stalled
  task automatic read_reg(input reg_addr_t a);
    drive_cycle(1'b0, '0, '0, 1'b0, 1'b1, a);
    idle_cycles(1);
    while (rd_stall_o) begin
      idle_cycles(1);
    end
  endtask

  ////////////////////////////////////////
  // Reference model and comparison
  ////////////////////////////////////////

  initial begin
    int r;
    int edge_cnt;
    logic cap, exp_cs, exp_tag, w_wait;
    logic [31:0] exp_data;
    reg_addr_t w_addr;
    edge_cnt = 0;
    w_wait = 1'b0;
    w_addr = '0;
    for (r = 0; r < NRegs; r++) begin
      m_data[r] = '0;
      m_tag[r] = 1'b0;
      m_clr[r] = 1'b0;
      m_due[r] = 0;
    end
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_ni) begin
        edge_cnt++;
        // Read decision sees the state before this edge
        if (!w_wait && rd_req_i) begin
          w_wait = 1'b1;
          w_addr = rd_addr_i;
        end
        cap = w_wait && (m_due[w_addr] == 0);
        exp_data = m_data[w_addr];
        exp_tag = m_tag[w_addr];
        if (cap) begin
          w_wait = 1'b0;
        end
        for (r = 1; r < NRegs; r++) begin
          if (m_due[r] == edge_cnt) begin
            m_tag[r] = m_tag[r] && !m_clr[r];
            m_due[r] = 0;
          end
        end
        exp_cs = wb_valid_i && (wb_addr_i != '0) && checked_write(wb_data_i, wb_tag_i);
        if (wb_valid_i && (wb_addr_i != '0)) begin
          m_data[wb_addr_i] = wb_data_i;
          m_tag[wb_addr_i] = wb_tag_i;
          m_due[wb_addr_i] = exp_cs ? edge_cnt + 2 : 0;
          m_clr[wb_addr_i] = exp_cs && expect_revoked(wb_data_i);
        end
        check_value("rd_valid_o", 32'(rd_valid_o), 32'(cap));
        check_value("rd_stall_o", 32'(rd_stall_o), 32'(w_wait));
        check_value("tsmap_cs_o", 32'(tsmap_cs_o), 32'(exp_cs));
        if (exp_cs) begin
          check_value("tsmap_addr_o", 32'(tsmap_addr_o),
                      ((wb_data_i - DefaultHeapBase) >> TsGranuleShift) / 32);
        end
        if (cap) begin
          check_value("rd_data_o", rd_data_o, exp_data);
          check_value("rd_tag_o", 32'(rd_tag_o), 32'(exp_tag));
          valid_cnt++;
        end
      end
    end
  end

  initial begin
    #(TimeoutNs);
    $display("Simulation timed out after %0d ns without finishing the tests", TimeoutNs);
    $display("SOME TESTS FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    int i;
    logic [31:0] r;
    rst_ni = 1'b1;
    wb_valid_i = 1'b0;
    wb_addr_i = '0;
    wb_data_i = '0;
    wb_tag_i = 1'b0;
    rd_req_i = 1'b0;
    rd_addr_i = '0;
    for (i = 0; i < DefaultTsMapSize; i++) begin
      ts_mem[i] = xorshift_next();
    end
    #1 rst_ni = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    // Reset contents
    for (i = 0; i < NRegs; i++) begin
      read_reg(reg_addr_t'(i));
    end
    // Writes that need no lookup
    write_reg(5'd1, 32'h1234_5678, 1'b0);
    write_reg(5'd2, DefaultHeapBase + 32'h40, 1'b0);
    write_reg(5'd3, DefaultHeapBase - 32'h8, 1'b1);
    write_reg(5'd4, DefaultHeapBase + HeapSpan, 1'b1);
    for (i = 1; i < 5; i++) begin
      read_reg(reg_addr_t'(i));
    end
    // Checked writes, resolved before the read
    for (i = 8; i < 16; i++) begin
      write_reg(reg_addr_t'(i), heap_rand(), 1'b1);
    end
    idle_cycles(4);
    for (i = 8; i < 16; i++) begin
      read_reg(reg_addr_t'(i));
    end
    // Reads that stall behind pending checks
    write_reg(5'd5, heap_rand(), 1'b1);
    read_reg(5'd5);
    write_reg(5'd6, heap_rand(), 1'b1);
    write_reg(5'd7, heap_rand(), 1'b1);
    read_reg(5'd6);
    read_reg(5'd7);
    // Pending check overtaken by a newer write
    write_reg(5'd9, heap_rand(), 1'b1);
    write_reg(5'd9, 32'hcafe_0009, 1'b0);
    write_reg(5'd10, heap_rand(), 1'b1);
    write_reg(5'd10, 32'h0000_1000, 1'b1);
    read_reg(5'd9);
    read_reg(5'd10);
    write_reg(5'd0, heap_rand(), 1'b1);
    read_reg(5'd0);

    for (i = 0; i < NumRandomOps; i++) begin
      r = xorshift_next();
      drive_cycle(r[0], r[8:4], r[1] ? heap_rand() : xorshift_next(), r[2], r[3], r[13:9]);
    end
    idle_cycles(1);
    while (rd_stall_o) begin
      idle_cycles(1);
    end
    idle_cycles(4);

    if ((valid_cnt > 0) && (assertion_failures() == 0)) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      if (valid_cnt == 0) begin
        $display("No read result was ever returned by the DUT");
      end else begin
        $display("Bound assertions failed %0d times", assertion_failures());
      end
      $display("SOME TESTS FAILED");
      $fatal(1, "Run failed");
    end
  end

endmodule
